// ==== source/tetris_pkg.sv ====
`default_nettype none

package tetris_pkg;

  ////////////////////////////////////////////////////
  // playfield geometry
  ////////////////////////////////////////////////////

  // row 0 is the top row, row 21 the floor row
  localparam int rows = 22;
  localparam int cols = 10;

  // frame origin of every new piece
  localparam int spawn_row = 0;
  localparam int spawn_col = 3;

  typedef logic [4:0] row_t;
  typedef logic [3:0] col_t;

  // code 0 is an empty cell, codes 1..7 follow piece kinds 0..6
  typedef enum logic [2:0] {
    color_empty,
    color_cyan,
    color_yellow,
    color_purple,
    color_green,
    color_red,
    color_blue,
    color_orange
  } color_t;

  // one row of 3-bit colour codes, column 0 in the low bits
  typedef logic [cols-1:0][2:0] cell_row_t;
  typedef cell_row_t [rows-1:0] grid_t;

  ////////////////////////////////////////////////////
  // commands and shapes
  ////////////////////////////////////////////////////

  // move_none is the null step used for the spawn check
  typedef enum logic [2:0] {
    move_right,
    move_left,
    move_rotr,
    move_rotl,
    move_down,
    move_none
  } move_t;

  typedef enum logic [2:0] {
    kind_i,
    kind_o,
    kind_t,
    kind_s,
    kind_z,
    kind_j,
    kind_l
  } piece_kind_t;

  // 4x4 occupancy mask, bit r*4+c is frame row r, column c
  function automatic logic [15:0] shape_cells(piece_kind_t kind, logic [1:0] rot);
    logic [15:0] mask;
    logic [15:0] turned;
    case (kind)
      kind_i:  mask = 16'h00f0;
      kind_o:  mask = 16'h0660;
      kind_t:  mask = 16'h0072;
      kind_s:  mask = 16'h0036;
      kind_z:  mask = 16'h0063;
      kind_j:  mask = 16'h0071;
      kind_l:  mask = 16'h0074;
      default: mask = 16'h0000;
    endcase
    // each step turns the frame a quarter clockwise about its centre
    for (int step = 0; step < 3; step++) begin
      if (2'(step) < rot) begin
        for (int r = 0; r < 4; r++) begin
          for (int c = 0; c < 4; c++) begin
            turned[r*4+c] = mask[(3-c)*4+r];
          end
        end
        mask = turned;
      end
    end
    return mask;
  endfunction

endpackage

`default_nettype wire

// ==== source/piece_if.sv ====
`default_nettype none

// next piece from generator to game controller
interface piece_if;
  logic                    valid;
  logic                    ready;
  tetris_pkg::piece_kind_t kind;
  tetris_pkg::color_t      color;

  // transfer on a clock with valid and ready both high
  modport source (output valid, output kind, output color, input ready);
  modport sink (input valid, input kind, input color, output ready);
endinterface

`default_nettype wire

// ==== source/clear_if.sv ====
`default_nettype none

// row removal request from controller to line clearer
interface clear_if;
  logic              start;
  tetris_pkg::grid_t grid_in;
  logic              busy;
  logic              done;
  tetris_pkg::grid_t grid_out;
  logic [4:0]        lines;

  // grid_out and lines hold from done until the next start
  modport requester (output start, output grid_in,
                     input busy, input done, input grid_out, input lines);
  modport worker (input start, input grid_in,
                  output busy, output done, output grid_out, output lines);
endinterface

`default_nettype wire

// ==== source/piece_source.sv ====
`default_nettype none

module piece_source #(
  parameter logic [15:0] lfsr_seed = 16'hace1
) (
  input logic      clk,
  input logic      rst,
  piece_if.source  pieces
);
  import tetris_pkg::*;

  // galois form, taps 16 14 13 11, shifting right
  localparam logic [15:0] lfsr_taps = 16'hb400;

  logic [15:0] lfsr;
  logic [15:0] lfsr_next;
  logic [2:0]  kind_code;
  logic        valid_q;

  assign lfsr_next = {1'b0, lfsr[15:1]} ^ (lfsr[0] ? lfsr_taps : 16'h0000);

  // kind is the state modulo 7
  assign kind_code = 3'(lfsr % 16'd7);

  ////////////////////////////////////////////////////
  // state only moves on a taken piece
  ////////////////////////////////////////////////////
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      lfsr    <= lfsr_seed;
      valid_q <= 1'b0;
    end else begin
      // never runs dry once out of reset
      valid_q <= 1'b1;
      if (pieces.valid && pieces.ready) begin
        lfsr <= lfsr_next;
      end
    end
  end

  assign pieces.valid = valid_q;
  assign pieces.kind  = piece_kind_t'(kind_code);
  // colour code sits one above the kind
  assign pieces.color = color_t'(kind_code + 3'd1);

  // every piece handed over is one of the seven shapes
  a_kind_range : assert property (@(posedge clk) disable iff (rst)
    pieces.valid && pieces.ready |-> pieces.kind <= kind_l);

endmodule

`default_nettype wire

// ==== source/move_check.sv ====
`default_nettype none

module move_check (
  input  tetris_pkg::grid_t       field,
  input  tetris_pkg::piece_kind_t kind,
  input  logic [1:0]              rot,
  input  tetris_pkg::row_t        row,
  input  logic signed [4:0]       col,
  input  tetris_pkg::move_t       move,
  output logic [1:0]              new_rot,
  output tetris_pkg::row_t        new_row,
  output logic signed [4:0]       new_col,
  output logic                    fits
);
  import tetris_pkg::*;

  logic [15:0]       mask;
  logic [5:0]        cell_r;
  logic signed [5:0] cell_c;

  ////////////////////////////////////////////////////
  // candidate frame
  ////////////////////////////////////////////////////
  always_comb begin
    new_rot = rot;
    new_row = row;
    new_col = col;
    case (move)
      move_right: new_col = col + 5'sd1;
      move_left:  new_col = col - 5'sd1;
      move_rotr:  new_rot = rot + 2'd1;
      move_rotl:  new_rot = rot - 2'd1;
      move_down:  new_row = row + 5'd1;
      // null step keeps the frame where it is
      default:    new_rot = rot;
    endcase
  end

  ////////////////////////////////////////////////////
  // collision test
  ////////////////////////////////////////////////////
  always_comb begin
    fits   = 1'b1;
    cell_r = '0;
    cell_c = '0;
    mask   = shape_cells(kind, new_rot);
    for (int r = 0; r < 4; r++) begin
      for (int c = 0; c < 4; c++) begin
        // one extra bit so row 22+ and negative columns show up
        cell_r = {1'b0, new_row} + 6'(r);
        cell_c = {new_col[4], new_col} + 6'(c);
        if (mask[r*4+c]) begin
          if (int'(cell_c) < 0 || int'(cell_c) >= cols || int'(cell_r) >= rows) begin
            fits = 1'b0;
          end else if (field[row_t'(cell_r)][col_t'(cell_c)] != color_empty) begin
            // landed on a locked cell
            fits = 1'b0;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/line_clear.sv ====
`default_nettype none

module line_clear (
  input logic      clk,
  input logic      rst,
  clear_if.worker  req
);
  import tetris_pkg::*;

  grid_t      work;
  row_t       ptr;
  logic [4:0] count;
  logic       busy;
  logic       done;
  logic       row_full;

  // full means no empty code anywhere in the row
  always_comb begin
    row_full = 1'b1;
    for (int c = 0; c < cols; c++) begin
      if (work[ptr][c] == color_empty) begin
        row_full = 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////
  // scan control, bottom row upward
  ////////////////////////////////////////////////////
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      busy  <= 1'b0;
      done  <= 1'b0;
      ptr   <= '0;
      count <= '0;
    end else begin
      done <= 1'b0;
      if (req.start && !busy) begin
        busy  <= 1'b1;
        ptr   <= row_t'(rows - 1);
        count <= '0;
      end else if (busy) begin
        if (row_full) begin
          // pointer stays, the shifted row gets rescanned
          count <= count + 5'd1;
        end else if (ptr == '0) begin
          busy <= 1'b0;
          done <= 1'b1;
        end else begin
          ptr <= ptr - 5'd1;
        end
      end
    end
  end

  // working copy of the grid
  always_ff @(posedge clk) begin
    if (req.start && !busy) begin
      work <= req.grid_in;
    end else if (busy && row_full) begin
      // everything above the full row drops one place
      for (int r = 1; r < rows; r++) begin
        if (5'(r) <= ptr) begin
          work[r] <= work[r-1];
        end
      end
      work[0] <= '0;
    end
  end

  assign req.busy     = busy;
  assign req.done     = done;
  assign req.grid_out = work;
  assign req.lines    = count;

  // controller must not restart a scan in flight
  a_no_start_busy : assert property (@(posedge clk) disable iff (rst)
    req.start |-> !req.busy);

endmodule

`default_nettype wire

// ==== source/game_ctrl.sv ====
`default_nettype none

module game_ctrl (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start,
  input  logic                  move_valid,
  input  tetris_pkg::move_t     move,
  output logic                  move_ready,
  piece_if.sink                 pieces,
  clear_if.requester            clr,
  input  tetris_pkg::row_t      rd_row,
  output tetris_pkg::cell_row_t rd_data,
  output logic                  game_over,
  output logic [7:0]            lines_total
);
  import tetris_pkg::*;

  typedef enum logic [2:0] {
    st_idle,
    st_spawn,
    st_play,
    st_lock,
    st_clear,
    st_over
  } state_t;

  state_t            state;
  grid_t             field;
  grid_t             merged;
  // active piece
  piece_kind_t       cur_kind;
  color_t            cur_color;
  logic [1:0]        cur_rot;
  row_t              cur_row;
  logic signed [4:0] cur_col;
  logic [15:0]       cur_mask;
  logic [5:0]        paint_r;
  logic signed [5:0] paint_c;
  // collision check inputs and results
  piece_kind_t       chk_kind;
  logic [1:0]        chk_rot;
  row_t              chk_row;
  logic signed [4:0] chk_col;
  move_t             chk_move;
  logic [1:0]        new_rot;
  row_t              new_row;
  logic signed [4:0] new_col;
  logic              fits;
  logic              row_full;
  logic              any_full;

  ////////////////////////////////////////////////////
  // collision check, shared by spawn and play
  ////////////////////////////////////////////////////
  always_comb begin
    if (state == st_spawn) begin
      // incoming piece at the spawn point, no step
      chk_kind = pieces.kind;
      chk_rot  = 2'd0;
      chk_row  = row_t'(spawn_row);
      chk_col  = 5'(spawn_col);
      chk_move = move_none;
    end else begin
      chk_kind = cur_kind;
      chk_rot  = cur_rot;
      chk_row  = cur_row;
      chk_col  = cur_col;
      chk_move = move;
    end
  end

  move_check u_check (
    .field   (field),
    .kind    (chk_kind),
    .rot     (chk_rot),
    .row     (chk_row),
    .col     (chk_col),
    .move    (chk_move),
    .new_rot (new_rot),
    .new_row (new_row),
    .new_col (new_col),
    .fits    (fits)
  );

  // locked field with the active piece painted in
  always_comb begin
    merged   = field;
    paint_r  = '0;
    paint_c  = '0;
    cur_mask = shape_cells(cur_kind, cur_rot);
    for (int r = 0; r < 4; r++) begin
      for (int c = 0; c < 4; c++) begin
        paint_r = {1'b0, cur_row} + 6'(r);
        paint_c = {cur_col[4], cur_col} + 6'(c);
        if (cur_mask[r*4+c] && int'(paint_r) < rows &&
            int'(paint_c) >= 0 && int'(paint_c) < cols) begin
          merged[row_t'(paint_r)][col_t'(paint_c)] = cur_color;
        end
      end
    end
  end

  // any complete row after the lock
  always_comb begin
    any_full = 1'b0;
    row_full = 1'b0;
    for (int r = 0; r < rows; r++) begin
      row_full = 1'b1;
      for (int c = 0; c < cols; c++) begin
        if (merged[r][c] == color_empty) begin
          row_full = 1'b0;
        end
      end
      if (row_full) begin
        any_full = 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////
  // game FSM
  ////////////////////////////////////////////////////
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state       <= st_idle;
      field       <= '0;
      lines_total <= '0;
    end else begin
      case (state)
        st_idle, st_over: begin
          // fresh game, empty field
          if (start) begin
            field       <= '0;
            lines_total <= '0;
            state       <= st_spawn;
          end
        end
        st_spawn: begin
          if (pieces.valid) begin
            state <= fits ? st_play : st_over;
          end
        end
        st_play: begin
          // only a blocked down move locks
          if (move_valid && !fits && move == move_down) begin
            state <= st_lock;
          end
        end
        st_lock: begin
          field <= merged;
          state <= any_full ? st_clear : st_spawn;
        end
        st_clear: begin
          if (clr.done) begin
            field       <= clr.grid_out;
            lines_total <= lines_total + 8'(clr.lines);
            state       <= st_spawn;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // active piece position
  always_ff @(posedge clk) begin
    if (state == st_spawn && pieces.valid) begin
      cur_kind  <= pieces.kind;
      cur_color <= pieces.color;
      cur_rot   <= 2'd0;
      cur_row   <= row_t'(spawn_row);
      cur_col   <= 5'(spawn_col);
    end else if (state == st_play && move_valid && fits) begin
      cur_rot <= new_rot;
      cur_row <= new_row;
      cur_col <= new_col;
    end
  end

  assign move_ready    = (state == st_play);
  assign game_over     = (state == st_over);
  assign pieces.ready  = (state == st_spawn);
  // clear request goes out in the lock cycle
  assign clr.start     = (state == st_lock) && any_full;
  assign clr.grid_in   = merged;

  // read port, piece drawn only while in play
  always_comb begin
    rd_data = '0;
    if (int'(rd_row) < rows) begin
      rd_data = (state == st_play) ? merged[rd_row] : field[rd_row];
    end
  end

  // no moves taken while clearing or fetching a piece
  a_ready_play : assert property (@(posedge clk) disable iff (rst)
    (clr.busy || pieces.ready) |-> !move_ready);

endmodule

`default_nettype wire

// ==== source/tetris_top.sv ====
`default_nettype none

module tetris_top #(
  parameter logic [15:0] lfsr_seed = 16'hace1
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start,
  input  logic                  move_valid,
  output logic                  move_ready,
  input  tetris_pkg::move_t     move,
  input  tetris_pkg::row_t      rd_row,
  output tetris_pkg::cell_row_t rd_data,
  output logic                  game_over,
  output logic [7:0]            lines_total
);

  // internal buses
  piece_if piece_bus ();
  clear_if clear_bus ();

  ////////////////////////////////////////////////////
  // blocks
  ////////////////////////////////////////////////////
  piece_source #(
    .lfsr_seed (lfsr_seed)
  ) u_source (
    .clk    (clk),
    .rst    (rst),
    .pieces (piece_bus.source)
  );

  game_ctrl u_ctrl (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .move_valid  (move_valid),
    .move        (move),
    .move_ready  (move_ready),
    .pieces      (piece_bus.sink),
    .clr         (clear_bus.requester),
    .rd_row      (rd_row),
    .rd_data     (rd_data),
    .game_over   (game_over),
    .lines_total (lines_total)
  );

  line_clear u_clear (
    .clk (clk),
    .rst (rst),
    .req (clear_bus.worker)
  );

endmodule

`default_nettype wire

// ==== verification/tetris_tb.sv ====
`default_nettype none

module tetris_tb;
  import tetris_pkg::*;

  // table op codes, start is the only non-move entry
  localparam int op_right = 0;
  localparam int op_left  = 1;
  localparam int op_rotr  = 2;
  localparam int op_rotl  = 3;
  localparam int op_down  = 4;
  localparam int op_start = 5;
  localparam int settle_max = 100;

  logic       clk = 1'b0;
  logic       rst;
  logic       start;
  logic       move_valid;
  logic       move_ready;
  move_t      move;
  row_t       rd_row;
  cell_row_t  rd_data;
  logic       game_over;
  logic [7:0] lines_total;

  // stimulus table: op, repeat count, check flag
  int op_q[$];
  int cnt_q[$];
  int chk_q[$];

  // reference model of field, piece and generator
  int m_field [rows][cols];
  int m_kind;
  int m_color;
  int m_rot;
  int m_row;
  int m_col;
  int m_lfsr;
  int m_lines;
  bit m_active;
  bit m_over;

  int seed = 32'h253f;
  int cycles = 0;
  int limit = 0;
  int tests = 0;
  int failed = 0;
  int errors = 0;

  tetris_top #(
    .lfsr_seed (16'hace1)
  ) uut (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .move_valid  (move_valid),
    .move_ready  (move_ready),
    .move        (move),
    .rd_row      (rd_row),
    .rd_data     (rd_data),
    .game_over   (game_over),
    .lines_total (lines_total)
  );

  always #10 clk = ~clk;

  // hang guard
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("timeout after %0d cycles, the DUT stopped making progress", cycles);
      $display("Done: errors found");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  // rotation 0 frames, bit r*4+c
  function automatic logic [15:0] shape_base(int kind);
    case (kind)
      0: return 16'h00f0;
      1: return 16'h0660;
      2: return 16'h0072;
      3: return 16'h0036;
      4: return 16'h0063;
      5: return 16'h0071;
      6: return 16'h0074;
      default: return 16'h0000;
    endcase
  endfunction

  function automatic bit cell_on(int kind, int rot, int r, int c);
    logic [15:0] mask;
    int sr;
    int sc;
    int t;
    mask = shape_base(kind);
    sr = r;
    sc = c;
    // undo one clockwise quarter turn per step
    for (int k = 0; k < rot; k++) begin
      t  = sr;
      sr = 3 - sc;
      sc = t;
    end
    return mask[4'(sr * 4 + sc)];
  endfunction

  function automatic bit piece_fits(int kind, int rot, int row, int col);
    bit ok;
    int rr;
    int cc;
    ok = 1'b1;
    for (int r = 0; r < 4; r++) begin
      for (int c = 0; c < 4; c++) begin
        rr = row + r;
        cc = col + c;
        if (cell_on(kind, rot, r, c)) begin
          if (cc < 0 || cc >= cols || rr >= rows) begin
            ok = 1'b0;
          end else if (m_field[rr][cc] != 0) begin
            ok = 1'b0;
          end
        end
      end
    end
    return ok;
  endfunction

  task automatic spawn_piece();
    m_kind  = m_lfsr % 7;
    m_color = m_kind + 1;
    // galois step, taps 16 14 13 11
    m_lfsr  = (m_lfsr >> 1) ^ (((m_lfsr & 1) != 0) ? 'hb400 : 0);
    m_rot   = 0;
    m_row   = spawn_row;
    m_col   = spawn_col;
    m_active = piece_fits(m_kind, m_rot, m_row, m_col);
    m_over   = !m_active;
  endtask

  task automatic lock_and_clear();
    int keep [rows][cols];
    int dst;
    bit full;
    for (int r = 0; r < 4; r++) begin
      for (int c = 0; c < 4; c++) begin
        if (cell_on(m_kind, m_rot, r, c)) begin
          m_field[m_row + r][m_col + c] = m_color;
        end
      end
    end
    for (int r = 0; r < rows; r++) begin
      for (int c = 0; c < cols; c++) begin
        keep[r][c] = 0;
      end
    end
    // keep non-full rows, packed toward the floor
    dst = rows - 1;
    for (int r = rows - 1; r >= 0; r--) begin
      full = 1'b1;
      for (int c = 0; c < cols; c++) begin
        if (m_field[r][c] == 0) begin
          full = 1'b0;
        end
      end
      if (full) begin
        m_lines = m_lines + 1;
      end else begin
        for (int c = 0; c < cols; c++) begin
          keep[dst][c] = m_field[r][c];
        end
        dst = dst - 1;
      end
    end
    for (int r = 0; r < rows; r++) begin
      for (int c = 0; c < cols; c++) begin
        m_field[r][c] = keep[r][c];
      end
    end
  endtask

  task automatic apply_ref_move(int op);
    int nrot;
    int nrow;
    int ncol;
    nrot = m_rot;
    nrow = m_row;
    ncol = m_col;
    case (op)
      op_right: ncol = m_col + 1;
      op_left:  ncol = m_col - 1;
      op_rotr:  nrot = (m_rot + 1) % 4;
      op_rotl:  nrot = (m_rot + 3) % 4;
      default:  nrow = m_row + 1;
    endcase
    if (piece_fits(m_kind, nrot, nrow, ncol)) begin
      m_rot = nrot;
      m_row = nrow;
      m_col = ncol;
    end else if (op == op_down) begin
      // blocked down locks, then the next piece
      lock_and_clear();
      spawn_piece();
    end
  endtask

  // start only counts from idle or game over
  task automatic restart_game();
    if (!m_active) begin
      for (int r = 0; r < rows; r++) begin
        for (int c = 0; c < cols; c++) begin
          m_field[r][c] = 0;
        end
      end
      m_lines = 0;
      spawn_piece();
    end
  endtask

  function automatic cell_row_t expected_row(int r);
    cell_row_t e;
    for (int c = 0; c < cols; c++) begin
      e[col_t'(c)] = 3'(m_field[r][c]);
    end
    // active piece drawn over the field in play
    if (m_active) begin
      for (int pr = 0; pr < 4; pr++) begin
        for (int pc = 0; pc < 4; pc++) begin
          if (cell_on(m_kind, m_rot, pr, pc) && m_row + pr == r) begin
            e[col_t'(m_col + pc)] = 3'(m_color);
          end
        end
      end
    end
    return e;
  endfunction

  //////////////////////////////////////////////////
  // stimulus and checks
  //////////////////////////////////////////////////

  function automatic move_t to_move(int op);
    case (op)
      op_right: return move_right;
      op_left:  return move_left;
      op_rotr:  return move_rotr;
      op_rotl:  return move_rotl;
      default:  return move_down;
    endcase
  endfunction

  function automatic string op_name(int op);
    case (op)
      op_right: return "right";
      op_left:  return "left";
      op_rotr:  return "rotr";
      op_rotl:  return "rotl";
      op_down:  return "down";
      default:  return "start";
    endcase
  endfunction

  task automatic add_entry(int op, int n, int chk);
    op_q.push_back(op);
    cnt_q.push_back(n);
    chk_q.push_back(chk);
  endtask

  // held until the DUT is ready, all driving at +2 after the edge
  task automatic issue_move(int op);
    move       = to_move(op);
    move_valid = 1'b1;
    while (!move_ready) begin
      @(posedge clk);
      #2;
    end
    @(posedge clk);
    #2;
    move_valid = 1'b0;
    apply_ref_move(op);
  endtask

  task automatic pulse_start();
    start = 1'b1;
    @(posedge clk);
    #2;
    start = 1'b0;
    restart_game();
  endtask

  task automatic check_dut(int test_no, string what);
    int bad;
    int waited;
    cell_row_t e;
    bad = 0;
    waited = 0;
    // lock, clear and spawn run on their own
    while (((m_active && !move_ready) || (m_over && !game_over)) && waited < settle_max) begin
      @(posedge clk);
      #2;
      waited = waited + 1;
    end
    if (waited >= settle_max) begin
      $display("test %0d: DUT never settled back in play or game over", test_no);
      bad = bad + 1;
    end
    if (move_ready !== m_active) begin
      $display("FAILED %0t: move_ready is %b, expected %b", $time, move_ready, m_active);
      bad = bad + 1;
    end
    if (game_over !== m_over) begin
      $display("FAILED %0t: game_over is %b, expected %b", $time, game_over, m_over);
      bad = bad + 1;
    end
    if (lines_total !== 8'(m_lines)) begin
      $display("FAILED %0t: lines_total is %0d, expected %0d", $time, lines_total, m_lines);
      bad = bad + 1;
    end
    // one row per cycle, sampled mid-cycle
    for (int r = 0; r < rows; r++) begin
      rd_row = row_t'(r);
      #8;
      e = expected_row(r);
      if (rd_data !== e) begin
        $display("FAILED %0t: row %0d reads %h, expected %h", $time, r, rd_data, e);
        bad = bad + 1;
      end
      @(posedge clk);
      #2;
    end
    tests = tests + 1;
    if (bad == 0) begin
      $display("test %0d (%s): ok", test_no, what);
    end else begin
      $display("test %0d (%s): %0d mismatches", test_no, what, bad);
      failed = failed + 1;
      errors = errors + bad;
    end
  endtask

  task automatic build_table();
    int pick;
    add_entry(op_start, 1, 1);
    // s to the left wall, one push past it
    add_entry(op_left, 3, 1);
    add_entry(op_left, 1, 1);
    add_entry(op_down, 21, 1);
    // o to the right wall
    add_entry(op_right, 4, 0);
    add_entry(op_right, 1, 1);
    add_entry(op_down, 20, 1);
    // z turned both ways and back
    add_entry(op_rotr, 1, 1);
    add_entry(op_rotl, 1, 1);
    add_entry(op_rotl, 1, 1);
    add_entry(op_rotr, 1, 1);
    add_entry(op_down, 21, 1);
    // t upside down, one right
    add_entry(op_rotr, 2, 0);
    add_entry(op_right, 1, 1);
    add_entry(op_down, 19, 1);
    add_entry(op_right, 4, 0);
    add_entry(op_down, 18, 1);
    add_entry(op_down, 19, 1);
    // upright i into column 0 should finish row 20
    add_entry(op_rotr, 1, 1);
    add_entry(op_left, 5, 0);
    add_entry(op_left, 1, 1);
    add_entry(op_down, 18, 1);
    // pile up at the spawn point until it collides
    add_entry(op_down, 500, 1);
    add_entry(op_start, 1, 1);
    // random run, biased toward down
    for (int k = 0; k < 100; k++) begin
      pick = $unsigned($random(seed)) % 4;
      add_entry((pick == 2) ? op_left : ((pick == 3) ? op_right : op_down),
                1 + $unsigned($random(seed)) % 3, 1);
    end
  endtask

  initial begin
    int steps;
    rst        = 1'b1;
    start      = 1'b0;
    move_valid = 1'b0;
    move       = move_down;
    rd_row     = '0;
    m_active   = 1'b0;
    m_over     = 1'b0;
    m_lines    = 0;
    m_lfsr     = 'hace1;
    for (int r = 0; r < rows; r++) begin
      for (int c = 0; c < cols; c++) begin
        m_field[r][c] = 0;
      end
    end
    build_table();
    // cycle budget per move and per check
    steps = 8;
    for (int i = 0; i < op_q.size(); i++) begin
      steps = steps + cnt_q[i] + 1;
    end
    limit = 40 * steps;

    repeat (8) @(posedge clk);
    #2;
    rst = 1'b0;
    check_dut(0, "reset");

    for (int i = 0; i < op_q.size(); i++) begin
      for (int n = 0; n < cnt_q[i]; n++) begin
        if (op_q[i] == op_start) begin
          pulse_start();
        end else if (m_active) begin
          issue_move(op_q[i]);
        end
      end
      if (chk_q[i] != 0) begin
        check_dut(i + 1, op_name(op_q[i]));
      end
    end

    $display("%0d tests run, %0d failed, %0d mismatches", tests, failed, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
source/tetris_pkg.sv
source/piece_if.sv
source/clear_if.sv
source/piece_source.sv
source/move_check.sv
source/line_clear.sv
source/game_ctrl.sv
source/tetris_top.sv
verification/tetris_tb.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench into sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert -f all.f --top-module tetris_tb -o tetris_sim
	./obj_dir/tetris_sim | tee sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log
